//--- files.f
+incdir+logic
logic/harness_pkg.sv
logic/addr_decoder.sv
logic/mem_bank.sv
logic/resp_mux.sv
logic/debug_gate.sv
logic/harness_top.sv
verif/harness_assertions.sv
verif/harness_tb.sv

//--- logic/addr_decoder.sv
// --------------------------------------------------------------------------
// Address decoder of the harness
// Range check against every bank, one-hot bank strobe, bank number and
// a miss flag for addresses outside all banks
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "harness_defs.svh"

module addr_decoder (
  input  logic                          req_i,
  input  harness_pkg::addr_t            addr_i,
  output logic [`HARNESS_NUM_BANKS-1:0] bank_req_o,
  output harness_pkg::word_idx_t        word_idx_o,
  output harness_pkg::bank_sel_t        sel_o,
  output logic                          miss_o
);

  import harness_pkg::*;

  // Low address bits select a byte inside the word
  localparam int unsigned ByteOffW  = $clog2(`HARNESS_BE_W);
  localparam int unsigned BankBytes = `HARNESS_BANK_WORDS * `HARNESS_BE_W;

  logic [`HARNESS_NUM_BANKS-1:0] hit;

  // ------------------------------------------------------------------------
  // Range check per bank
  // ------------------------------------------------------------------------
  always_comb begin : p_range
    addr_t base;
    base  = '0;
    hit   = '0;
    sel_o = '0;
    for (int unsigned k = 0; k < `HARNESS_NUM_BANKS; k++) begin
      base = addr_t'(`HARNESS_BANK_BASE + k * `HARNESS_BANK_STRIDE);
      // Only the lower 2 KiB of each stride is backed by memory
      if (addr_i >= base && addr_i < base + addr_t'(BankBytes)) begin
        hit[k] = 1'b1;
        sel_o  = bank_sel_t'(k);
      end
    end
  end

  // Strobe only the bank that was hit
  assign bank_req_o = hit & {`HARNESS_NUM_BANKS{req_i}};

  // No region matched
  assign miss_o = req_i & ~(|hit);

  // Word index within the bank
  assign word_idx_o = addr_i[ByteOffW +: `HARNESS_WORD_IDX_W];

endmodule

//--- logic/debug_gate.sv
// --------------------------------------------------------------------------
// Debug request gate
// Post-reset hold-off counter and enable gating of the debug request
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "harness_defs.svh"

module debug_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  import harness_pkg::*;

  delay_cnt_t cnt_d;
  delay_cnt_t cnt_q;

  // Count down to zero and stay there
  assign cnt_d = (cnt_q != '0) ? cnt_q - delay_cnt_t'(1) : '0;

  // Gives the system time to settle before the first debug request
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      cnt_q <= delay_cnt_t'(`HARNESS_DEBUG_DELAY);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Blocked while counting, then passed through when enabled
  assign debug_req_o = (cnt_q == '0) & debug_en_i & debug_req_i;

endmodule

//--- logic/harness_defs.svh
// --------------------------------------------------------------------------
// Shared widths and sizes of the memory harness
// Address map of the SRAM banks and the debug hold-off length
// --------------------------------------------------------------------------

`ifndef HARNESS_DEFS_SVH
`define HARNESS_DEFS_SVH

// Request bus widths
`define HARNESS_ADDR_W      32
`define HARNESS_DATA_W      64
`define HARNESS_BE_W        8

// Bank geometry, 256 words of 8 bytes gives 2 KiB per bank
`define HARNESS_NUM_BANKS   4
`define HARNESS_BANK_WORDS  256
`define HARNESS_WORD_IDX_W  8

// ------------------------------------------------------------------------
// Address map
// ------------------------------------------------------------------------
// Bank k starts at base + k * stride
`define HARNESS_BANK_BASE   32'h8000_0000
// Upper half of each stride is left unmapped
`define HARNESS_BANK_STRIDE 32'h0000_1000

// Cycles after reset before a debug request is let through
`define HARNESS_DEBUG_DELAY 50

`endif

//--- logic/harness_pkg.sv
// --------------------------------------------------------------------------
// Vector types shared by the harness RTL and its testbench
// --------------------------------------------------------------------------

`include "harness_defs.svh"

package harness_pkg;

  // Byte address on the request bus
  typedef logic [`HARNESS_ADDR_W-1:0] addr_t;

  // One data word and its byte enables
  typedef logic [`HARNESS_DATA_W-1:0] data_t;
  typedef logic [`HARNESS_BE_W-1:0]   be_t;

  // Word index inside one bank
  typedef logic [`HARNESS_WORD_IDX_W-1:0] word_idx_t;

  // Bank number
  typedef logic [$clog2(`HARNESS_NUM_BANKS)-1:0] bank_sel_t;

  // Debug hold-off counter, must hold the full delay value
  typedef logic [$clog2(`HARNESS_DEBUG_DELAY+1)-1:0] delay_cnt_t;

endpackage

//--- logic/harness_top.sv
// --------------------------------------------------------------------------
// Top level of the memory harness
// Address decoder, a row of SRAM banks, the response stage and the
// debug request gate
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "harness_defs.svh"

module harness_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Request bus
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::be_t   be_i,
  input  harness_pkg::data_t wdata_i,
  // Response, one cycle after the request
  output logic               rvalid_o,
  output logic               err_o,
  output harness_pkg::data_t rdata_o,
  // Debug request
  input  logic               debug_req_i,
  input  logic               debug_en_i,
  output logic               debug_req_o
);

  import harness_pkg::*;

  logic [`HARNESS_NUM_BANKS-1:0] bank_req;
  word_idx_t                     word_idx;
  bank_sel_t                     sel;
  logic                          miss;
  data_t                         bank_rdata [`HARNESS_NUM_BANKS];

  // ------------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------------
  addr_decoder i_addr_decoder (
    .req_i      ( req_i    ),
    .addr_i     ( addr_i   ),
    .bank_req_o ( bank_req ),
    .word_idx_o ( word_idx ),
    .sel_o      ( sel      ),
    .miss_o     ( miss     )
  );

  // ------------------------------------------------------------------------
  // SRAM banks
  // ------------------------------------------------------------------------
  // Write data, enables and index are shared, only the strobe differs
  for (genvar k = 0; k < `HARNESS_NUM_BANKS; k++) begin : g_bank
    mem_bank i_mem_bank (
      .clk_i      ( clk_i         ),
      .req_i      ( bank_req[k]   ),
      .we_i       ( we_i          ),
      .word_idx_i ( word_idx      ),
      .be_i       ( be_i          ),
      .wdata_i    ( wdata_i       ),
      .rdata_o    ( bank_rdata[k] )
    );
  end

  // ------------------------------------------------------------------------
  // Response
  // ------------------------------------------------------------------------
  resp_mux i_resp_mux (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .we_i         ( we_i       ),
    .miss_i       ( miss       ),
    .sel_i        ( sel        ),
    .bank_rdata_i ( bank_rdata ),
    .rvalid_o     ( rvalid_o   ),
    .err_o        ( err_o      ),
    .rdata_o      ( rdata_o    )
  );

  // ------------------------------------------------------------------------
  // Debug
  // ------------------------------------------------------------------------
  debug_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- logic/mem_bank.sv
// --------------------------------------------------------------------------
// Single SRAM bank
// Byte-enabled writes and a registered read port, one cycle latency
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "harness_defs.svh"

module mem_bank (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  harness_pkg::word_idx_t word_idx_i,
  input  harness_pkg::be_t       be_i,
  input  harness_pkg::data_t     wdata_i,
  output harness_pkg::data_t     rdata_o
);

  import harness_pkg::*;

  localparam int unsigned ByteW = `HARNESS_DATA_W / `HARNESS_BE_W;

  // Storage array
  data_t mem_q [`HARNESS_BANK_WORDS];

  // ------------------------------------------------------------------------
  // Read and write port
  // ------------------------------------------------------------------------
  // Every strobe returns the word as it was before this cycle's write
  always_ff @(posedge clk_i) begin : p_mem
    if (req_i) begin
      rdata_o <= mem_q[word_idx_i];
      if (we_i) begin
        for (int unsigned b = 0; b < `HARNESS_BE_W; b++) begin
          // Update enabled bytes only
          if (be_i[b]) begin
            mem_q[word_idx_i][b*ByteW +: ByteW] <= wdata_i[b*ByteW +: ByteW];
          end
        end
      end
    end
  end

endmodule

//--- logic/resp_mux.sv
// --------------------------------------------------------------------------
// Response stage of the harness
// One register stage for request info, bank read data merge and the
// error response for unmapped addresses
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "harness_defs.svh"

module resp_mux (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic                   miss_i,
  input  harness_pkg::bank_sel_t sel_i,
  input  harness_pkg::data_t     bank_rdata_i [`HARNESS_NUM_BANKS],
  output logic                   rvalid_o,
  output logic                   err_o,
  output harness_pkg::data_t     rdata_o
);

  import harness_pkg::*;

  logic      req_q;
  logic      we_q;
  logic      miss_q;
  bank_sel_t sel_q;

  // ------------------------------------------------------------------------
  // Request pipeline register
  // ------------------------------------------------------------------------
  // Lines up with the bank read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pipe
    if (!rst_ni) begin
      req_q  <= 1'b0;
      we_q   <= 1'b0;
      miss_q <= 1'b0;
      sel_q  <= '0;
    end else begin
      req_q  <= req_i;
      we_q   <= we_i;
      miss_q <= miss_i;
      sel_q  <= sel_i;
    end
  end

  // ------------------------------------------------------------------------
  // Response forming
  // ------------------------------------------------------------------------
  // Every request gets exactly one response pulse
  assign rvalid_o = req_q;

  // Error slave behaviour for unmapped addresses
  assign err_o = miss_q;

  // Data only for a read that hit a bank
  assign rdata_o = (req_q && !we_q && !miss_q) ? bank_rdata_i[sel_q] : '0;

endmodule

//--- run.sh
#!/bin/sh
# Build the harness testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module harness_tb -f files.f -o harness_sim \
  || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/harness_sim)
echo "$sim_out"

# Pass only when the testbench printed its pass line
echo "$sim_out" | grep -q "^Result: PASSED$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- verif/harness_assertions.sv
// --------------------------------------------------------------------------
// Concurrent timing assertions of the memory harness
// Response timing, error flag and debug hold-off, bound to the top level
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "harness_defs.svh"

module harness_assertions (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    req_i,
  input logic                    rvalid_o,
  input logic                    err_o,
  input logic                    debug_req_o,
  input harness_pkg::delay_cnt_t cnt_i
);

  // Response pulse exactly one cycle after each request
  a_rvalid_follows_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) rvalid_o == $past(req_i)
  ) else $error("rvalid_o is not a one-cycle delayed copy of req_i");

  // Error only comes with a response
  a_err_with_rvalid : assert property (
    @(posedge clk_i) disable iff (!rst_ni) err_o |-> rvalid_o
  ) else $error("err_o is high without rvalid_o");

  // Debug request blocked during the hold-off window
  a_debug_held_off : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (cnt_i != '0) |-> !debug_req_o
  ) else $error("debug_req_o is high while the hold-off counter runs");

endmodule

bind harness_top harness_assertions i_harness_assertions (
  .clk_i       ( clk_i                    ),
  .rst_ni      ( rst_ni                   ),
  .req_i       ( req_i                    ),
  .rvalid_o    ( rvalid_o                 ),
  .err_o       ( err_o                    ),
  .debug_req_o ( debug_req_o              ),
  .cnt_i       ( i_debug_gate.cnt_q       )
);

//--- verif/harness_tb.sv
// --------------------------------------------------------------------------
// Testbench of the memory harness
// Clock and reset, directed and random request traffic, debug gate
// stimulus, shadow-bank reference model and response checks
// --------------------------------------------------------------------------

`timescale 1ns/1ns

`include "harness_defs.svh"

module harness_tb;

  import harness_pkg::*;

  localparam int unsigned ByteW      = `HARNESS_DATA_W / `HARNESS_BE_W;
  localparam int unsigned BankBytes  = `HARNESS_BANK_WORDS * `HARNESS_BE_W;
  localparam int unsigned RandomReqs = 300;
  // Limit set well above the length of all tests
  localparam int unsigned TimeoutCycles = 2000;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t data;
  } resp_t;

  logic  clk_i;
  logic  rst_ni;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  be_t   be_i;
  data_t wdata_i;
  logic  rvalid_o;
  logic  err_o;
  data_t rdata_o;
  logic  debug_req_i;
  logic  debug_en_i;
  logic  debug_req_o;

  // Shadow copy of every bank
  data_t shadow  [`HARNESS_NUM_BANKS][`HARNESS_BANK_WORDS];
  bit    written [`HARNESS_NUM_BANKS][`HARNESS_BANK_WORDS];

  resp_t       exp_q [$];
  resp_t       pending;
  logic [31:0] rng_state;
  int unsigned cycle_count = 0;
  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned test_count  = 0;

  harness_top i_dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .rvalid_o    ( rvalid_o    ),
    .err_o       ( err_o       ),
    .rdata_o     ( rdata_o     ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Random numbers and address helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic addr_t bank_addr(input int unsigned bank, input int unsigned idx);
    return addr_t'(`HARNESS_BANK_BASE + bank * `HARNESS_BANK_STRIDE + idx * `HARNESS_BE_W);
  endfunction

  // Below the map, in a stride hole, or above the last bank
  function automatic addr_t unmapped_addr(input logic [31:0] rnd);
    addr_t a;
    case (rnd[1:0])
      2'd0:    a = {1'b0, rnd[31:1]};
      2'd3:    a = addr_t'(`HARNESS_BANK_BASE + `HARNESS_NUM_BANKS * `HARNESS_BANK_STRIDE)
                   | {2'b00, rnd[29:0]};
      default: a = addr_t'(`HARNESS_BANK_BASE + 32'(rnd[3:2]) * `HARNESS_BANK_STRIDE
                   + BankBytes + 32'(rnd[14:4]));
    endcase
    return a;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic void map_lookup(input addr_t addr, output logic hit,
                                     output int unsigned bank, output int unsigned idx);
    addr_t offset;
    offset = addr - `HARNESS_BANK_BASE;
    hit    = 1'b0;
    bank   = 0;
    idx    = 0;
    if (addr >= `HARNESS_BANK_BASE &&
        offset < `HARNESS_NUM_BANKS * `HARNESS_BANK_STRIDE &&
        (offset % `HARNESS_BANK_STRIDE) < BankBytes) begin
      hit  = 1'b1;
      bank = offset / `HARNESS_BANK_STRIDE;
      idx  = (offset % `HARNESS_BANK_STRIDE) / `HARNESS_BE_W;
    end
  endfunction

  function automatic resp_t ref_response(input logic we, input addr_t addr);
    resp_t       r;
    logic        hit;
    int unsigned bank;
    int unsigned idx;
    map_lookup(addr, hit, bank, idx);
    r.valid = 1'b1;
    r.err   = ~hit;
    r.data  = (hit && !we) ? shadow[bank][idx] : '0;
    return r;
  endfunction

  // Byte-enable merge into the shadow word
  function automatic void shadow_write(input addr_t addr, input be_t be, input data_t wdata);
    logic        hit;
    int unsigned bank;
    int unsigned idx;
    map_lookup(addr, hit, bank, idx);
    if (hit) begin
      for (int unsigned b = 0; b < `HARNESS_BE_W; b++) begin
        if (be[b]) begin
          shadow[bank][idx][b*ByteW +: ByteW] = wdata[b*ByteW +: ByteW];
        end
      end
      written[bank][idx] = 1'b1;
    end
  endfunction

  // --------------------------------------------------------------------------
  // Checks and reporting
  // --------------------------------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      $display("Test %0d %s: %0d errors", test_count, name, error_count - errs_before);
    end
  endtask

  // Response of the request registered one cycle earlier
  always @(posedge clk_i) begin : compare_responses
    resp_t idle_resp;
    idle_resp = '0;
    if (rst_ni) begin
      check_bit("rvalid_o", rvalid_o, pending.valid);
      check_bit("err_o", err_o, pending.err);
      check_word("rdata_o", rdata_o, pending.data);
      if (exp_q.size() != 0) begin
        pending = exp_q.pop_front();
      end else begin
        pending = idle_resp;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Request driver
  // --------------------------------------------------------------------------
  task automatic send(input logic we, input addr_t addr, input be_t be, input data_t wdata);
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    exp_q.push_back(ref_response(we, addr));
    if (we) begin
      shadow_write(addr, be, wdata);
    end
  endtask

  // Idle bus, then wait until the last response was checked
  task automatic drain();
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
    @(negedge clk_i);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic test_debug_gate();
    int unsigned errs;
    errs        = error_count;
    debug_req_i = 1'b1;
    debug_en_i  = 1'b1;
    rst_ni      = 1'b1;
    for (int unsigned p = 1; p <= 60; p++) begin
      @(posedge clk_i);
      if (p <= 49) begin
        check_bit("debug_req_o", debug_req_o, 1'b0);
      end else if (p >= 51) begin
        check_bit("debug_req_o", debug_req_o, 1'b1);
      end
    end
    @(negedge clk_i);
    debug_en_i = 1'b0;
    @(posedge clk_i);
    check_bit("debug_req_o", debug_req_o, 1'b0);
    // Enable back on so the output follows the request
    for (int unsigned t = 0; t < 8; t++) begin
      @(negedge clk_i);
      debug_en_i  = 1'b1;
      debug_req_i = t[0] ^ t[2];
      @(posedge clk_i);
      check_bit("debug_req_o", debug_req_o, t[0] ^ t[2]);
    end
    report_test("debug gate", errs);
  endtask

  task automatic test_full_words();
    int unsigned errs;
    int unsigned idx_list [4];
    errs     = error_count;
    idx_list = '{0, 1, 100, 255};
    for (int unsigned b = 0; b < `HARNESS_NUM_BANKS; b++) begin
      for (int unsigned i = 0; i < 4; i++) begin
        send(1'b1, bank_addr(b, idx_list[i]), '1,
             {8'(b), 8'(i), 16'hc0de, next_rand()});
      end
    end
    for (int unsigned b = 0; b < `HARNESS_NUM_BANKS; b++) begin
      for (int unsigned i = 0; i < 4; i++) begin
        send(1'b0, bank_addr(b, idx_list[i]), '0, '0);
      end
    end
    drain();
    report_test("full-word write and read", errs);
  endtask

  task automatic test_byte_enables();
    int unsigned errs;
    addr_t       a;
    be_t         be_list [6];
    errs    = error_count;
    a       = bank_addr(2, 7);
    be_list = '{8'h01, 8'h80, 8'h3c, 8'ha5, 8'h00, 8'h5a};
    send(1'b1, a, '1, 64'h0123_4567_89ab_cdef);
    send(1'b0, a, '0, '0);
    for (int unsigned i = 0; i < 6; i++) begin
      send(1'b1, a, be_list[i], {next_rand(), next_rand()});
      send(1'b0, a, '0, '0);
    end
    drain();
    report_test("byte-enable merge", errs);
  endtask

  task automatic test_unmapped();
    int unsigned errs;
    addr_t       miss_addrs [$];
    errs = error_count;
    miss_addrs.push_back(32'h0000_0000);
    miss_addrs.push_back(32'h7fff_fff8);
    for (int unsigned b = 0; b < `HARNESS_NUM_BANKS; b++) begin
      miss_addrs.push_back(bank_addr(b, 0) + addr_t'(BankBytes));
      miss_addrs.push_back(bank_addr(b, 0) + addr_t'(`HARNESS_BANK_STRIDE - 4));
    end
    miss_addrs.push_back(bank_addr(`HARNESS_NUM_BANKS, 0));
    miss_addrs.push_back(32'hffff_fff8);
    foreach (miss_addrs[i]) begin
      send(1'b1, miss_addrs[i], '1, {next_rand(), next_rand()});
      send(1'b0, miss_addrs[i], '0, '0);
    end
    // Mapped words that a wrongly decoded miss would hit
    for (int unsigned b = 0; b < `HARNESS_NUM_BANKS; b++) begin
      send(1'b0, bank_addr(b, 0), '0, '0);
      send(1'b0, bank_addr(b, 255), '0, '0);
    end
    drain();
    report_test("unmapped addresses", errs);
  endtask

  task automatic test_random_traffic();
    int unsigned errs;
    logic [31:0] r;
    logic [31:0] be_rnd;
    logic        we;
    addr_t       a;
    data_t       wdata;
    logic        hit;
    int unsigned bank;
    int unsigned idx;
    errs = error_count;
    for (int unsigned n = 0; n < RandomReqs; n++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        a = unmapped_addr(next_rand());
      end else begin
        bank = next_rand() % `HARNESS_NUM_BANKS;
        idx  = next_rand() % `HARNESS_BANK_WORDS;
        a    = bank_addr(bank, idx) | addr_t'(r[6:4]);
      end
      we = r[3];
      map_lookup(a, hit, bank, idx);
      // Reads only go to words that hold data
      if (hit && !we && !written[bank][idx]) begin
        we = 1'b1;
      end
      be_rnd   = next_rand();
      wdata    = {next_rand(), next_rand()};
      send(we, a, be_rnd[7:0], wdata);
    end
    drain();
    report_test("back-to-back random traffic", errs);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin : main
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    be_i        = '0;
    wdata_i     = '0;
    debug_req_i = 1'b0;
    debug_en_i  = 1'b0;
    rng_state   = 32'd70;
    pending     = '0;
    repeat (5) @(negedge clk_i);
    test_debug_gate();
    test_full_words();
    test_byte_enables();
    test_unmapped();
    test_random_traffic();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
